// File: logic/cache_pkg.sv
package cache_pkg;

    //////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////

    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 16;
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 3;
    localparam int LINE_W   = 64;
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [INDEX_W-1:0]            index_t;
    typedef logic [LINE_W-1:0]             line_t;
    typedef logic [ADDR_W-1:0]             addr_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]   way_t;
    typedef logic [NUM_WAYS-1:0]           way_vec_t;

    // Tree state. Bit 2 picks the half, bit 1 picks within ways 0/1,
    // bit 0 picks within ways 2/3. A zero bit points at the lower way.
    typedef logic [NUM_WAYS-2:0]           plru_t;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic   rd;
        logic   wr;
        logic   wdirty;
        index_t index;
        tag_t   tag;
        line_t  wmask;
        line_t  wdata;
    } cache_req_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t data;
    } way_out_t;

    // Merge set means a masked update of a hit line, clear means a full fill.
    typedef struct packed {
        logic  en;
        logic  merge;
        logic  dirty;
        line_t wmask;
        line_t data;
    } way_wr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        line_t data;
    } wb_req_t;

endpackage

// File: logic/cache_way_store.sv
`timescale 1ns/1ns

module cache_way_store
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  index_t   index,
    input  tag_t     tag,
    input  way_wr_t  wr,
    output way_out_t way
);

    tag_t                tag_mem  [NUM_SETS];
    line_t               data_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    line_t               old_line;
    line_t               new_line;

    // Reads are combinational at the request index.
    assign old_line  = data_mem[index];
    assign way.valid = valid_q[index];
    assign way.dirty = dirty_q[index];
    assign way.tag   = tag_mem[index];
    assign way.data  = old_line;

    // A hit keeps the unmasked bits of the stored line.
    assign new_line = wr.merge ? ((old_line & ~wr.wmask) | (wr.data & wr.wmask))
                               : wr.data;

    //////////////////////////////////////////////////
    // Flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr.en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= wr.dirty;
        end
    end

    //////////////////////////////////////////////////
    // Tag and data arrays
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= new_line;
        end
    end

endmodule

// File: logic/cache_lookup_decode.sv
`timescale 1ns/1ns

module cache_lookup_decode
    import cache_pkg::*;
(
    input  tag_t     tag,
    input  way_out_t ways [NUM_WAYS],
    output way_vec_t hit_vec,
    output logic     hit
);

    // A way hits only with a valid entry whose stored tag matches.
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = ways[w].valid && (ways[w].tag == tag);
        end
    end

    assign hit = |hit_vec;

endmodule

// File: logic/cache_replace_execute.sv
`timescale 1ns/1ns

module cache_replace_execute
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cache_req_t req,
    input  way_vec_t   hit_vec,
    input  logic       hit,
    input  way_vec_t   valid_vec,
    input  way_vec_t   dirty_vec,
    output way_wr_t    way_wr [NUM_WAYS],
    output way_t       victim,
    output logic       evict
);

    plru_t plru_table [NUM_SETS];
    plru_t cur_plru;
    plru_t next_plru;
    logic  access;
    logic  miss;

    assign access   = req.rd | req.wr;
    assign miss     = access & ~hit;
    assign cur_plru = plru_table[req.index];

    //////////////////////////////////////////////////
    // Victim choice
    //////////////////////////////////////////////////

    always_comb begin
        if (!cur_plru[2]) begin
            victim = cur_plru[1] ? way_t'(1) : way_t'(0);
        end else begin
            victim = cur_plru[0] ? way_t'(3) : way_t'(2);
        end
    end

    // Only a dirty, valid victim needs to go back to memory.
    assign evict = miss & valid_vec[victim] & dirty_vec[victim];

    // Writes go to the hit way, or on a miss fill the victim whole.
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_wr[w].en    = req.wr & (hit ? hit_vec[w] : (victim == way_t'(w)));
            way_wr[w].merge = hit;
            way_wr[w].dirty = req.wdirty;
            way_wr[w].wmask = req.wmask;
            way_wr[w].data  = req.wdata;
        end
    end

    //////////////////////////////////////////////////
    // Replacement state
    //////////////////////////////////////////////////

    // Point the tree away from the way that was just used.
    always_comb begin
        next_plru = cur_plru;
        if (hit_vec[0]) begin
            next_plru[2:1] = 2'b11;
        end else if (hit_vec[1]) begin
            next_plru[2:1] = 2'b10;
        end else if (hit_vec[2]) begin
            next_plru[2] = 1'b0;
            next_plru[0] = 1'b1;
        end else if (hit_vec[3]) begin
            next_plru[2] = 1'b0;
            next_plru[0] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_table[s] <= '0;
            end
        end else if (access && hit) begin
            plru_table[req.index] <= next_plru;
        end
    end

endmodule

// File: logic/cache_result.sv
`timescale 1ns/1ns

module cache_result
    import cache_pkg::*;
(
    input  logic     rd,
    input  index_t   index,
    input  way_vec_t hit_vec,
    input  way_t     victim,
    input  logic     evict,
    input  way_out_t ways [NUM_WAYS],
    output line_t    rdata,
    output wb_req_t  wb
);

    line_t hit_line;

    // At most one way hits, so the lines can simply be ORed.
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_line = hit_line | ways[w].data;
            end
        end
    end

    assign rdata = rd ? hit_line : '0;

    //////////////////////////////////////////////////
    // Write-back of the evicted line
    //////////////////////////////////////////////////

    always_comb begin
        wb.en   = evict;
        wb.addr = '0;
        wb.data = '0;
        if (evict) begin
            wb.addr = {ways[victim].tag, index, {OFFSET_W{1'b0}}};
            wb.data = ways[victim].data;
        end
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/1ns

module cache_top
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cache_req_t req,
    output logic       hit,
    output line_t      rdata,
    output wb_req_t    wb
);

    way_out_t ways   [NUM_WAYS];
    way_wr_t  way_wr [NUM_WAYS];
    way_vec_t hit_vec;
    way_vec_t valid_vec;
    way_vec_t dirty_vec;
    way_t     victim;
    logic     evict;

    //////////////////////////////////////////////////
    // Way storage
    //////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        cache_way_store u_way_store (
            .clk   (clk),
            .rst_n (rst_n),
            .index (req.index),
            .tag   (req.tag),
            .wr    (way_wr[g]),
            .way   (ways[g])
        );

        assign valid_vec[g] = ways[g].valid;
        assign dirty_vec[g] = ways[g].dirty;
    end

    //////////////////////////////////////////////////
    // Lookup, replacement and outputs
    //////////////////////////////////////////////////

    cache_lookup_decode u_decode (
        .tag     (req.tag),
        .ways    (ways),
        .hit_vec (hit_vec),
        .hit     (hit)
    );

    cache_replace_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .hit_vec   (hit_vec),
        .hit       (hit),
        .valid_vec (valid_vec),
        .dirty_vec (dirty_vec),
        .way_wr    (way_wr),
        .victim    (victim),
        .evict     (evict)
    );

    cache_result u_result (
        .rd      (req.rd),
        .index   (req.index),
        .hit_vec (hit_vec),
        .victim  (victim),
        .evict   (evict),
        .ways    (ways),
        .rdata   (rdata),
        .wb      (wb)
    );

endmodule

// File: verif/cache_model.svh
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

//////////////////////////////////////////////////
// Reference model state
//////////////////////////////////////////////////

typedef struct packed {
    logic    hit;
    line_t   rdata;
    wb_req_t wb;
} expect_t;

logic  m_valid [NUM_WAYS][NUM_SETS];
logic  m_dirty [NUM_WAYS][NUM_SETS];
tag_t  m_tag   [NUM_WAYS][NUM_SETS];
line_t m_data  [NUM_WAYS][NUM_SETS];
plru_t m_plru  [NUM_SETS];

task automatic model_reset();
    for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
        end
        m_plru[s] = '0;
    end
endtask

// Predicts the outputs of one access, then applies its state updates.
function automatic expect_t predict(input cache_req_t r);
    expect_t e;
    logic    acc;
    int      hw;
    int      vic;
    plru_t   p;
    e   = '0;
    acc = r.rd | r.wr;
    hw  = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
        if (m_valid[w][r.index] && (m_tag[w][r.index] == r.tag)) begin
            hw = w;
        end
    end
    p = m_plru[r.index];
    if (p[2] == 1'b0) begin
        vic = p[1] ? 1 : 0;
    end else begin
        vic = p[0] ? 3 : 2;
    end
    e.hit = (hw >= 0);
    if (r.rd && e.hit) begin
        e.rdata = m_data[hw][r.index];
    end
    if (acc && !e.hit && m_valid[vic][r.index] && m_dirty[vic][r.index]) begin
        e.wb.en   = 1'b1;
        e.wb.addr = {m_tag[vic][r.index], r.index, 3'b000};
        e.wb.data = m_data[vic][r.index];
    end
    if (r.wr && e.hit) begin
        m_data[hw][r.index]  = (m_data[hw][r.index] & ~r.wmask) | (r.wdata & r.wmask);
        m_dirty[hw][r.index] = r.wdirty;
    end else if (r.wr) begin
        m_valid[vic][r.index] = 1'b1;
        m_dirty[vic][r.index] = r.wdirty;
        m_tag[vic][r.index]   = r.tag;
        m_data[vic][r.index]  = r.wdata;
    end
    // The tree only moves on hits.
    if (acc && e.hit) begin
        case (hw)
            0: begin p[2] = 1'b1; p[1] = 1'b1; end
            1: begin p[2] = 1'b1; p[1] = 1'b0; end
            2: begin p[2] = 1'b0; p[0] = 1'b1; end
            default: begin p[2] = 1'b0; p[0] = 1'b0; end
        endcase
        m_plru[r.index] = p;
    end
    return e;
endfunction

`endif

// File: verif/cache_tb.sv
`timescale 1ns/1ns

module cache_tb
    import cache_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 39;
    localparam int NUM_RANDOM      = 400;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + NUM_RANDOM + 2;
    localparam int TIMEOUT_NS      = TOTAL_CYCLES * CLK_PERIOD + 200;

    `include "cache_model.svh"

    logic       clk;
    logic       rst_n;
    cache_req_t req;
    logic       hit;
    line_t      rdata;
    wb_req_t    wb;

    logic       checking;
    string      test_name;
    int         seed;
    int         r;
    int         hit_cnt;
    int         evict_cnt;
    expect_t    exp_out;

    cache_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .hit   (hit),
        .rdata (rdata),
        .wb    (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "output check");
        end
    endtask

    task automatic drive_access(input string name, input logic rd, input logic wr,
                                input logic wdirty, input index_t idx, input tag_t tag,
                                input line_t mask, input line_t data);
        @(posedge clk);
        #1;
        test_name  = name;
        req.rd     = rd;
        req.wr     = wr;
        req.wdirty = wdirty;
        req.index  = idx;
        req.tag    = tag;
        req.wmask  = mask;
        req.wdata  = data;
    endtask

    task automatic do_read(input string name, input index_t idx, input tag_t tag);
        drive_access(name, 1'b1, 1'b0, 1'b0, idx, tag, '0, '0);
    endtask

    task automatic do_write(input string name, input index_t idx, input tag_t tag,
                            input line_t mask, input line_t data, input logic dirty);
        drive_access(name, 1'b0, 1'b1, dirty, idx, tag, mask, data);
    endtask

    //////////////////////////////////////////////////
    // Compare, one cycle at a time
    //////////////////////////////////////////////////

    always begin
        @(posedge clk);
        #(CLK_PERIOD - 1);
        if (checking) begin
            exp_out = predict(req);
            check({test_name, " hit"}, exp_out.hit, hit);
            check({test_name, " rdata"}, exp_out.rdata, rdata);
            check({test_name, " wb"}, exp_out.wb, wb);
            // The random mix alone has to reach hits and evictions.
            if (test_name == "random") begin
                if (hit && (req.rd || req.wr)) begin
                    hit_cnt++;
                end
                if (wb.en) begin
                    evict_cnt++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = '0;
        checking  = 1'b0;
        test_name = "idle";
        seed      = 32'h6288d28a;
        hit_cnt   = 0;
        evict_cnt = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        checking = 1'b1;

        for (int s = 0; s < NUM_SETS; s++) begin
            do_read("reset", index_t'(s), tag_t'(s + 5));
        end

        do_write("fill", 1, 'h100, 64'h0000_0000_0000_00ff, 64'h1122_3344_5566_7788, 1'b1);
        do_read("fill", 1, 'h100);
        do_write("merge", 1, 'h100, 64'h00ff_00ff_0000_ff00, 64'hdead_beef_cafe_f00d, 1'b1);
        do_read("merge", 1, 'h100);

        // A hit after each fill steers the next fill into an empty way.
        for (int t = 0; t < 4; t++) begin
            do_write("replace", 2, tag_t'('h200 + t), '1, {32'h0a0a_0000, t}, 1'b1);
            do_read("replace", 2, tag_t'('h200 + t));
        end
        do_read("replace", 2, 'h202);
        do_read("replace", 2, 'h200);
        do_read("replace", 2, 'h203);
        do_read("replace", 2, 'h201);
        do_write("replace", 2, 'h2f0, '1, 64'h5555_aaaa_5555_aaaa, 1'b1);
        do_read("replace", 2, 'h2f1);

        do_write("evict", 3, 'h300, '1, 64'h0000_0000_0000_0300, 1'b0);
        do_write("evict", 3, 'h301, '1, 64'h0000_0000_0000_0301, 1'b0);
        do_write("evict", 3, 'h302, '1, 64'h0000_0000_0000_0302, 1'b1);
        do_write("evict", 3, 'h303, '1, 64'h0000_0000_0000_0303, 1'b1);
        do_write("evict", 4, 'h400, '1, 64'h0000_0000_0000_0400, 1'b1);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            drive_access("random", r[0], r[1], r[10], index_t'(r[9:8]),
                         tag_t'(32'h500 + (r[7:4] % 6)),
                         r[11] ? '1 : {$random(seed), $random(seed)},
                         {$random(seed), $random(seed)});
        end

        drive_access("idle", 1'b0, 1'b0, 1'b0, '0, '0, '0, '0);
        @(posedge clk);
        #1;
        if (hit_cnt > 0 && evict_cnt > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("The random mix never produced both a hit and an eviction");
            $display("Result: FAILED");
            $fatal(1, "stimulus coverage");
        end
    end

endmodule

// File: l1_cache.f
+incdir+verif
logic/cache_pkg.sv
logic/cache_way_store.sv
logic/cache_lookup_decode.sv
logic/cache_replace_execute.sv
logic/cache_result.sv
logic/cache_top.sv
verif/cache_tb.sv
